// File: common/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Flit and header geometry
`define NOC_FLIT_W      32
`define NOC_COORD_W     2   // Mesh of up to 4 x 4
`define NOC_LEN_W       3   // Payload flits after the header

// Router shape
`define NOC_PORTS       5
`define NOC_CHANNELS    10  // Two planes per port

// Input buffering
`define NOC_FIFO_DEPTH  16

// Position after reset
`define NOC_DEF_X       1
`define NOC_DEF_Y       1

`endif

// File: common/noc_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

    // First flit of every packet
    typedef struct packed {
        logic [`NOC_COORD_W-1:0] dest_x;
        logic [`NOC_COORD_W-1:0] dest_y;
        logic [`NOC_LEN_W-1:0]   len;      // 0 to 4 payload flits
        logic [2:0]              src_port;
        logic [7:0]              seq;
        logic [13:0]             tag;      // Free for software use
    } noc_header_t;

    // Header on the first flit, raw payload on the rest
    typedef union packed {
        noc_header_t            hdr;
        logic [`NOC_FLIT_W-1:0] data;
    } noc_flit_t;

    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_NORTH = 3'd1,
        PORT_EAST  = 3'd2,
        PORT_SOUTH = 3'd3,
        PORT_WEST  = 3'd4
    } noc_port_e;

endpackage

`default_nettype wire

// File: hw/stream_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module stream_fifo #(
    parameter int DEPTH = `NOC_FIFO_DEPTH
) (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire noc_pkg::noc_flit_t wr_data_i,
    input  wire logic               wr_valid_i,
    output logic                    wr_ready_o,
    output noc_pkg::noc_flit_t      rd_data_o,
    output logic                    rd_valid_o,
    input  wire logic               rd_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    noc_pkg::noc_flit_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_wr;
    logic               do_rd;

    assign wr_ready_o = (count_q != CNT_W'(DEPTH));
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = mem[rd_ptr_q];  // Head sits at the read pointer
    assign do_wr      = wr_valid_i & wr_ready_o;
    assign do_rd      = rd_valid_o & rd_ready_i;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count_q <= count_q + 1'b1;
            end else if (do_rd && !do_wr) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // A write into a full buffer would land on the head
    a_head_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rd_valid_o && !rd_ready_i) |=> (rd_valid_o && $stable(rd_data_o)));

    a_count_matches: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((int'(wr_ptr_q) - int'(rd_ptr_q) - int'(count_q)) % DEPTH) == 0);

endmodule

`default_nettype wire

// File: router/packet_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module packet_arbiter (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n_i,
    input  wire logic                                 plane_en_i,
    input  wire noc_pkg::noc_flit_t [`NOC_PORTS-1:0]  q_data_i,
    input  wire logic [`NOC_PORTS-1:0]                q_valid_i,
    output logic [`NOC_PORTS-1:0]                     q_ready_o,
    output noc_pkg::noc_flit_t                        pkt_data_o,
    output logic                                      pkt_valid_o,
    input  wire logic                                 pkt_ready_i,
    output logic                                      pkt_first_o
);

    localparam int IDX_W = $clog2(`NOC_PORTS);

    logic                  busy_q;
    logic                  first_q;
    logic [IDX_W-1:0]      grant_q;
    logic [IDX_W-1:0]      rr_ptr_q;
    logic [`NOC_LEN_W-1:0] remain_q;
    logic [IDX_W-1:0]      grant_next;
    logic                  pick_found;
    logic [IDX_W-1:0]      pick_idx;
    logic                  xfer;
    logic                  last_flit;
    noc_pkg::noc_flit_t    head;

    // Search starts at the pointer, lowest offset wins
    always_comb begin : rr_pick
        int cand;
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int k = `NOC_PORTS - 1; k >= 0; k--) begin
            cand = (int'(rr_ptr_q) + k) % `NOC_PORTS;
            if (q_valid_i[cand]) begin
                pick_found = 1'b1;
                pick_idx   = IDX_W'(cand);
            end
        end
    end

    assign grant_next  = (grant_q == IDX_W'(`NOC_PORTS - 1)) ? '0 : grant_q + 1'b1;
    assign head        = q_data_i[grant_q];
    assign pkt_data_o  = head;
    assign pkt_valid_o = busy_q & q_valid_i[grant_q];
    assign pkt_first_o = busy_q & first_q;
    assign xfer        = pkt_valid_o & pkt_ready_i;
    assign last_flit   = first_q ? (head.hdr.len == '0) : (remain_q == `NOC_LEN_W'(1));

    always_comb begin
        q_ready_o = '0;
        if (busy_q) begin
            q_ready_o[grant_q] = pkt_ready_i;  // Only the granted queue sees ready
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q   <= 1'b0;
            first_q  <= 1'b0;
            grant_q  <= '0;
            rr_ptr_q <= '0;
            remain_q <= '0;
        end else if (!busy_q) begin
            if (plane_en_i && pick_found) begin
                busy_q  <= 1'b1;
                first_q <= 1'b1;
                grant_q <= pick_idx;
            end
        end else if (xfer) begin
            first_q  <= 1'b0;
            remain_q <= first_q ? head.hdr.len : remain_q - 1'b1;
            if (last_flit) begin
                busy_q   <= 1'b0;
                rr_ptr_q <= grant_next;  // Next search begins past this winner
            end
        end
    end

    // A stalled flit stays on offer from the same queue
    a_stall_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        (pkt_valid_o && !pkt_ready_i) |=>
            (pkt_valid_o && $stable(pkt_data_o) && $stable(pkt_first_o)));

    a_len_range: assert property (@(posedge clk) disable iff (!arst_n_i)
        (pkt_valid_o && pkt_first_o) |-> (pkt_data_o.hdr.len <= `NOC_LEN_W'(4)));

endmodule

`default_nettype wire

// File: router/xy_route.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module xy_route (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n_i,
    input  wire logic [`NOC_COORD_W-1:0]              router_x_i,
    input  wire logic [`NOC_COORD_W-1:0]              router_y_i,
    input  wire noc_pkg::noc_flit_t                   pkt_data_i,
    input  wire logic                                 pkt_valid_i,
    output logic                                      pkt_ready_o,
    input  wire logic                                 pkt_first_i,
    output noc_pkg::noc_flit_t [`NOC_PORTS-1:0]       out_data_o,
    output logic [`NOC_PORTS-1:0]                     out_valid_o,
    input  wire logic [`NOC_PORTS-1:0]                out_ready_i
);

    noc_pkg::noc_header_t hdr;
    noc_pkg::noc_port_e   route_port;
    noc_pkg::noc_port_e   port_q;
    noc_pkg::noc_port_e   sel_port;

    assign hdr = pkt_data_i.hdr;

    // X first, then Y
    always_comb begin
        if (hdr.dest_x > router_x_i) begin
            route_port = noc_pkg::PORT_EAST;
        end else if (hdr.dest_x < router_x_i) begin
            route_port = noc_pkg::PORT_WEST;
        end else if (hdr.dest_y > router_y_i) begin
            route_port = noc_pkg::PORT_NORTH;
        end else if (hdr.dest_y < router_y_i) begin
            route_port = noc_pkg::PORT_SOUTH;
        end else begin
            route_port = noc_pkg::PORT_LOCAL;
        end
    end

    assign sel_port    = pkt_first_i ? route_port : port_q;
    assign pkt_ready_o = out_ready_i[sel_port];
    assign out_data_o  = {`NOC_PORTS{pkt_data_i}};  // Valid picks the real receiver

    always_comb begin
        out_valid_o           = '0;
        out_valid_o[sel_port] = pkt_valid_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            port_q <= noc_pkg::PORT_LOCAL;
        end else if (pkt_valid_i && pkt_ready_o && pkt_first_i) begin
            port_q <= route_port;  // Held for the payload flits
        end
    end

    // A stalled flit keeps its port and its data until it is taken
    a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (|(out_valid_o & ~out_ready_i)) |=> ($stable(out_valid_o) && $stable(out_data_o)));

endmodule

`default_nettype wire

// File: router/router_cfg.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module router_cfg (
    input  wire logic                    clk,
    input  wire logic                    arst_n_i,
    input  wire logic                    cfg_we_i,
    input  wire logic [`NOC_COORD_W-1:0] cfg_x_i,
    input  wire logic [`NOC_COORD_W-1:0] cfg_y_i,
    input  wire logic [1:0]              cfg_plane_en_i,
    output logic [`NOC_COORD_W-1:0]      router_x_o,
    output logic [`NOC_COORD_W-1:0]      router_y_o,
    output logic [1:0]                   plane_en_o
);

    // Bit 0 enables requests, bit 1 responses
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            router_x_o <= `NOC_COORD_W'(`NOC_DEF_X);
            router_y_o <= `NOC_COORD_W'(`NOC_DEF_Y);
            plane_en_o <= 2'b11;
        end else if (cfg_we_i) begin
            router_x_o <= cfg_x_i;
            router_y_o <= cfg_y_i;
            plane_en_o <= cfg_plane_en_i;
        end
    end

endmodule

`default_nettype wire

// File: router/router_dual_parallel.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module router_dual_parallel (
    input  wire logic                                    clk,
    input  wire logic                                    arst_n_i,
    input  wire noc_pkg::noc_flit_t [`NOC_CHANNELS-1:0]  in_data_i,
    input  wire logic [`NOC_CHANNELS-1:0]                in_valid_i,
    output wire logic [`NOC_CHANNELS-1:0]                in_ready_o,
    output wire noc_pkg::noc_flit_t [`NOC_CHANNELS-1:0]  out_data_o,
    output wire logic [`NOC_CHANNELS-1:0]                out_valid_o,
    input  wire logic [`NOC_CHANNELS-1:0]                out_ready_i,
    input  wire logic                                    cfg_we_i,
    input  wire logic [`NOC_COORD_W-1:0]                 cfg_x_i,
    input  wire logic [`NOC_COORD_W-1:0]                 cfg_y_i,
    input  wire logic [1:0]                              cfg_plane_en_i
);

    wire noc_pkg::noc_flit_t [`NOC_CHANNELS-1:0] q_data;
    wire logic [`NOC_CHANNELS-1:0]               q_valid;
    wire logic [`NOC_CHANNELS-1:0]               q_ready;
    wire noc_pkg::noc_flit_t [`NOC_PORTS-1:0]    req_q_data;
    wire logic [`NOC_PORTS-1:0]                  req_q_valid;
    wire logic [`NOC_PORTS-1:0]                  req_q_ready;
    wire noc_pkg::noc_flit_t [`NOC_PORTS-1:0]    resp_q_data;
    wire logic [`NOC_PORTS-1:0]                  resp_q_valid;
    wire logic [`NOC_PORTS-1:0]                  resp_q_ready;
    wire noc_pkg::noc_flit_t                     req_pkt_data;
    wire logic                                   req_pkt_valid;
    wire logic                                   req_pkt_ready;
    wire logic                                   req_pkt_first;
    wire noc_pkg::noc_flit_t                     resp_pkt_data;
    wire logic                                   resp_pkt_valid;
    wire logic                                   resp_pkt_ready;
    wire logic                                   resp_pkt_first;
    wire noc_pkg::noc_flit_t [`NOC_PORTS-1:0]    req_out_data;
    wire logic [`NOC_PORTS-1:0]                  req_out_valid;
    wire logic [`NOC_PORTS-1:0]                  req_out_ready;
    wire noc_pkg::noc_flit_t [`NOC_PORTS-1:0]    resp_out_data;
    wire logic [`NOC_PORTS-1:0]                  resp_out_valid;
    wire logic [`NOC_PORTS-1:0]                  resp_out_ready;
    wire logic [`NOC_COORD_W-1:0]                router_x;
    wire logic [`NOC_COORD_W-1:0]                router_y;
    wire logic [1:0]                             plane_en;

    for (genvar c = 0; c < `NOC_CHANNELS; c++) begin : g_fifo
        stream_fifo #(.DEPTH(`NOC_FIFO_DEPTH)) q (
            .clk(clk), .arst_n_i(arst_n_i),
            .wr_data_i(in_data_i[c]), .wr_valid_i(in_valid_i[c]), .wr_ready_o(in_ready_o[c]),
            .rd_data_o(q_data[c]), .rd_valid_o(q_valid[c]), .rd_ready_i(q_ready[c])
        );
    end

    // Even channels carry requests, odd channels responses
    for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_plane
        assign req_q_data[p]       = q_data[2*p];
        assign req_q_valid[p]      = q_valid[2*p];
        assign q_ready[2*p]        = req_q_ready[p];
        assign resp_q_data[p]      = q_data[2*p+1];
        assign resp_q_valid[p]     = q_valid[2*p+1];
        assign q_ready[2*p+1]      = resp_q_ready[p];
        assign out_data_o[2*p]     = req_out_data[p];
        assign out_valid_o[2*p]    = req_out_valid[p];
        assign req_out_ready[p]    = out_ready_i[2*p];
        assign out_data_o[2*p+1]   = resp_out_data[p];
        assign out_valid_o[2*p+1]  = resp_out_valid[p];
        assign resp_out_ready[p]   = out_ready_i[2*p+1];
    end

    packet_arbiter arb_req (
        .clk(clk), .arst_n_i(arst_n_i), .plane_en_i(plane_en[0]),
        .q_data_i(req_q_data), .q_valid_i(req_q_valid), .q_ready_o(req_q_ready),
        .pkt_data_o(req_pkt_data), .pkt_valid_o(req_pkt_valid),
        .pkt_ready_i(req_pkt_ready), .pkt_first_o(req_pkt_first)
    );

    packet_arbiter arb_resp (
        .clk(clk), .arst_n_i(arst_n_i), .plane_en_i(plane_en[1]),
        .q_data_i(resp_q_data), .q_valid_i(resp_q_valid), .q_ready_o(resp_q_ready),
        .pkt_data_o(resp_pkt_data), .pkt_valid_o(resp_pkt_valid),
        .pkt_ready_i(resp_pkt_ready), .pkt_first_o(resp_pkt_first)
    );

    xy_route alg_req (
        .clk(clk), .arst_n_i(arst_n_i), .router_x_i(router_x), .router_y_i(router_y),
        .pkt_data_i(req_pkt_data), .pkt_valid_i(req_pkt_valid),
        .pkt_ready_o(req_pkt_ready), .pkt_first_i(req_pkt_first),
        .out_data_o(req_out_data), .out_valid_o(req_out_valid), .out_ready_i(req_out_ready)
    );

    xy_route alg_resp (
        .clk(clk), .arst_n_i(arst_n_i), .router_x_i(router_x), .router_y_i(router_y),
        .pkt_data_i(resp_pkt_data), .pkt_valid_i(resp_pkt_valid),
        .pkt_ready_o(resp_pkt_ready), .pkt_first_i(resp_pkt_first),
        .out_data_o(resp_out_data), .out_valid_o(resp_out_valid), .out_ready_i(resp_out_ready)
    );

    router_cfg cfg (
        .clk(clk), .arst_n_i(arst_n_i), .cfg_we_i(cfg_we_i),
        .cfg_x_i(cfg_x_i), .cfg_y_i(cfg_y_i), .cfg_plane_en_i(cfg_plane_en_i),
        .router_x_o(router_x), .router_y_o(router_y), .plane_en_o(plane_en)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;  // Released away from the rising edge
    end

endmodule

`default_nettype wire

// File: verif/tb_router_dual_parallel.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module tb_router_dual_parallel;

    localparam int PKTS_PER_PHASE = 6;
    localparam int PHASES         = 4;
    localparam int MAX_FLITS      = PHASES * `NOC_CHANNELS * PKTS_PER_PHASE * 5;
    localparam int CYCLE_LIMIT    = 20 * MAX_FLITS + 2000;

    logic                                   clk;
    logic                                   arst_n;
    noc_pkg::noc_flit_t [`NOC_CHANNELS-1:0] in_data;
    logic [`NOC_CHANNELS-1:0]               in_valid;
    logic [`NOC_CHANNELS-1:0]               in_ready;
    noc_pkg::noc_flit_t [`NOC_CHANNELS-1:0] out_data;
    logic [`NOC_CHANNELS-1:0]               out_valid;
    logic [`NOC_CHANNELS-1:0]               out_ready;
    logic                                   cfg_we;
    logic [`NOC_COORD_W-1:0]                cfg_x;
    logic [`NOC_COORD_W-1:0]                cfg_y;
    logic [1:0]                             cfg_plane_en;

    logic [31:0]              rng;
    noc_pkg::noc_flit_t       send_q [`NOC_CHANNELS][$];  // Not yet accepted by the DUT
    noc_pkg::noc_flit_t       exp_q  [`NOC_CHANNELS][$];  // Not yet delivered
    logic [7:0]               seq_cnt [`NOC_CHANNELS];
    logic [`NOC_COORD_W-1:0]  model_x;
    logic [`NOC_COORD_W-1:0]  model_y;
    logic                     resp_off;
    logic [`NOC_CHANNELS-1:0] hold_mask;
    logic [`NOC_CHANNELS-1:0] held_valid;
    noc_pkg::noc_flit_t       held_data [`NOC_CHANNELS];
    logic [1:0]               pl_busy;  // Packet in flight per plane
    int                       pl_out [2];
    int                       pl_src [2];
    int                       pl_left [2];
    int                       cycle_cnt;

    tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(8)) i_clock_gen (.clk_o(clk), .arst_n_o(arst_n));

    router_dual_parallel i_router_dual_parallel (
        .clk(clk), .arst_n_i(arst_n),
        .in_data_i(in_data), .in_valid_i(in_valid), .in_ready_o(in_ready),
        .out_data_o(out_data), .out_valid_o(out_valid), .out_ready_i(out_ready),
        .cfg_we_i(cfg_we), .cfg_x_i(cfg_x), .cfg_y_i(cfg_y), .cfg_plane_en_i(cfg_plane_en)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Dimension order, X before Y
    function automatic noc_pkg::noc_port_e xy_port(input noc_pkg::noc_header_t h,
            input logic [`NOC_COORD_W-1:0] x, input logic [`NOC_COORD_W-1:0] y);
        if (h.dest_x > x) return noc_pkg::PORT_EAST;
        if (h.dest_x < x) return noc_pkg::PORT_WEST;
        if (h.dest_y > y) return noc_pkg::PORT_NORTH;
        if (h.dest_y < y) return noc_pkg::PORT_SOUTH;
        return noc_pkg::PORT_LOCAL;
    endfunction

    function automatic int plane_pending(input int p);
        int n;
        n = 0;
        for (int k = 0; k < `NOC_PORTS; k++) begin
            n += exp_q[2*k+p].size();
        end
        return n;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flit(input string name, input noc_pkg::noc_flit_t got,
            input noc_pkg::noc_flit_t want);
        if (got !== want) begin
            stop_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got.data, want.data));
        end
    endtask

    task automatic check_port(input string name, input noc_pkg::noc_port_e got,
            input noc_pkg::noc_port_e want);
        if (got !== want) begin
            stop_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_mask(input string name, input logic [`NOC_CHANNELS-1:0] got,
            input logic [`NOC_CHANNELS-1:0] want);
        if (got !== want) begin
            stop_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, want));
        end
    endtask

    task automatic queue_packet(input int ch);
        noc_pkg::noc_flit_t f;
        int                 len;
        rng             = xorshift32(rng);
        f.data          = '0;
        f.hdr.dest_x    = (rng[9:8] == 2'b00) ? model_x : rng[1:0];  // One in four stays here
        f.hdr.dest_y    = (rng[9:8] == 2'b00) ? model_y : rng[3:2];
        len             = int'(rng[6:4]) % 5;
        f.hdr.len       = `NOC_LEN_W'(len);
        f.hdr.src_port  = 3'(ch / 2);
        f.hdr.seq       = seq_cnt[ch];
        f.hdr.tag       = rng[29:16];
        seq_cnt[ch]     = seq_cnt[ch] + 8'd1;
        send_q[ch].push_back(f);
        exp_q[ch].push_back(f);
        for (int i = 0; i < len; i++) begin
            rng    = xorshift32(rng);
            f.data = rng;
            send_q[ch].push_back(f);
            exp_q[ch].push_back(f);
        end
    endtask

    task automatic queue_traffic();
        for (int k = 0; k < PKTS_PER_PHASE; k++) begin
            for (int c = 0; c < `NOC_CHANNELS; c++) begin
                queue_packet(c);
            end
        end
    endtask

    task automatic take_flit(input int o, input noc_pkg::noc_flit_t f);
        int                 p;
        int                 ch;
        noc_pkg::noc_port_e here;
        noc_pkg::noc_flit_t want;
        p    = o % 2;
        here = noc_pkg::noc_port_e'(3'(o / 2));
        if (pl_busy[p]) begin
            check_port("out_valid_o payload port", here,
                noc_pkg::noc_port_e'(3'(pl_out[p] / 2)));
            want = exp_q[pl_src[p]].pop_front();
            check_flit("out_data_o payload", f, want);
            pl_left[p] = pl_left[p] - 1;
            pl_busy[p] = (pl_left[p] != 0);
        end else if (f.hdr.src_port >= 3'(`NOC_PORTS)) begin
            stop_run($sformatf("output %0d delivered a header with an unknown source port", o));
        end else begin
            ch = 2 * int'(f.hdr.src_port) + p;  // Same plane it entered on
            if (exp_q[ch].size() == 0) begin
                stop_run($sformatf("output %0d delivered a packet that was never sent", o));
            end
            want = exp_q[ch].pop_front();
            check_flit("out_data_o header", f, want);
            check_port("out_valid_o header port", here, xy_port(want.hdr, model_x, model_y));
            pl_out[p]  = o;
            pl_src[p]  = ch;
            pl_left[p] = int'(want.hdr.len);
            pl_busy[p] = (want.hdr.len != '0);
        end
    endtask

    task automatic sample_outputs();
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            stop_run($sformatf("timeout after %0d cycles with %0d flits undelivered",
                cycle_cnt, plane_pending(0) + plane_pending(1)));
        end
        for (int c = 0; c < `NOC_CHANNELS; c++) begin
            if (in_valid[c] && in_ready[c]) begin
                void'(send_q[c].pop_front());
            end
            if (held_valid[c]) begin
                if (!out_valid[c]) begin
                    stop_run($sformatf("out_valid_o[%0d] dropped before its flit was taken", c));
                end
                check_flit($sformatf("out_data_o[%0d] while stalled", c), out_data[c], held_data[c]);
            end
            if (resp_off && (c % 2 == 1) && out_valid[c]) begin
                stop_run($sformatf("response output %0d went valid with its plane disabled", c));
            end
            held_valid[c] = out_valid[c] && !out_ready[c];
            held_data[c]  = out_data[c];
            if (out_valid[c] && out_ready[c]) begin
                take_flit(c, out_data[c]);
            end
        end
    endtask

    task automatic drive_inputs();
        rng = xorshift32(rng);
        for (int c = 0; c < `NOC_CHANNELS; c++) begin
            out_ready[c] = (rng[2*c +: 2] != 2'b00) && !hold_mask[c];  // Ready 75% of cycles
            in_valid[c]  = (send_q[c].size() != 0);
            if (in_valid[c]) begin
                in_data[c] = send_q[c][0];
            end
        end
    endtask

    // Outputs sampled on the rising edge, inputs driven on the falling edge
    task automatic step();
        @(posedge clk);
        sample_outputs();
        @(negedge clk);
        drive_inputs();
    endtask

    task automatic write_cfg(input logic [`NOC_COORD_W-1:0] x, input logic [`NOC_COORD_W-1:0] y,
            input logic [1:0] en);
        cfg_x        = x;
        cfg_y        = y;
        cfg_plane_en = en;
        cfg_we       = 1'b1;
        step();
        cfg_we  = 1'b0;
        model_x = x;
        model_y = y;
    endtask

    task automatic wait_drain();
        while (plane_pending(0) + plane_pending(1) != 0 || pl_busy != 2'b00) begin
            step();
        end
    endtask

    initial begin : main
        rng          = 32'h6f4;
        in_data      = '0;
        in_valid     = '0;
        out_ready    = '0;
        cfg_we       = 1'b0;
        cfg_x        = `NOC_COORD_W'(`NOC_DEF_X);
        cfg_y        = `NOC_COORD_W'(`NOC_DEF_Y);
        cfg_plane_en = 2'b11;
        model_x      = `NOC_COORD_W'(`NOC_DEF_X);
        model_y      = `NOC_COORD_W'(`NOC_DEF_Y);
        resp_off     = 1'b0;
        hold_mask    = '0;
        held_valid   = '0;
        pl_busy      = '0;
        cycle_cnt    = 0;
        for (int c = 0; c < `NOC_CHANNELS; c++) begin
            seq_cnt[c]   = '0;
            held_data[c] = '0;
        end
        for (int p = 0; p < 2; p++) begin
            pl_out[p]  = 0;
            pl_src[p]  = 0;
            pl_left[p] = 0;
        end

        @(posedge arst_n);
        step();
        check_mask("in_ready_o", in_ready, '1);
        check_mask("out_valid_o", out_valid, '0);

        queue_traffic();
        wait_drain();

        // Requests keep moving while responses wait in their FIFOs
        write_cfg(model_x, model_y, 2'b01);
        resp_off = 1'b1;
        queue_traffic();
        while (plane_pending(0) != 0 || pl_busy[0]) begin
            step();
        end
        write_cfg(model_x, model_y, 2'b11);
        resp_off = 1'b0;
        wait_drain();

        hold_mask[4] = 1'b1;  // East port, both planes
        hold_mask[5] = 1'b1;
        queue_traffic();
        repeat (60) step();
        hold_mask = '0;
        wait_drain();

        write_cfg(2'd2, 2'd3, 2'b11);
        queue_traffic();
        wait_drain();

        repeat (20) step();  // Stray or repeated flits would show up here
        check_mask("out_valid_o", out_valid, '0);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: router_dual_parallel.f
+incdir+common
common/noc_pkg.sv
hw/stream_fifo.sv
router/packet_arbiter.sv
router/xy_route.sv
router/router_cfg.sv
router/router_dual_parallel.sv
verif/tb_clock_gen.sv
verif/tb_router_dual_parallel.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run with Verilator, then search the log for the failure line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_router_dual_parallel \
    -f router_dual_parallel.f -o tb_router_dual_parallel > sim.log 2>&1 \
    && ./obj_dir/tb_router_dual_parallel >> sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
exit 0
